//--- src/qbridge_consts.svh
////////////////////////////////////////
// Register bridge constants
// Widths, host offsets, Qbus addresses, bit positions
////////////////////////////////////////
`ifndef QBRIDGE_CONSTS_SVH
`define QBRIDGE_CONSTS_SVH

// Widths
`define QB_DATA_W   16              // One register word
`define QB_DAL_W    16              // Qbus data/address lines used here
`define QB_HOST_AW  3               // Host word address

// Host word addresses
`define QB_HOST_IP  3'd0
`define QB_HOST_SA  3'd1
`define QB_HOST_CT  3'd2

// Qbus I/O page addresses, decoded on bits 12:1
`define QB_QADDR_IP 16'o172150
`define QB_QADDR_SA 16'o172152

// Control and flag bit positions
`define QB_CT_CLEARSA 12            // Host IP read also clears SA address
`define QB_FLAG_IPRD  0
`define QB_FLAG_IPWR  1
`define QB_FLAG_SARD  2
`define QB_FLAG_SAWR  3

`endif

//--- src/qbridgePkg.sv
////////////////////////////////////////
// Shared types of the register bridge
////////////////////////////////////////
`default_nettype none

`include "qbridge_consts.svh"

package qbridgePkg;

    ////////////////////////////////////////
    // Request decode

    // Target register of a request
    typedef enum logic [1:0]
    {
        regNone,                    // Unmapped, reads zero, no effect
        regIp,
        regSa,
        regCt
    } regSelT;

    // Issuer of a request
    typedef enum logic
    {
        srcHost,
        srcQbus
    } reqSrcT;

    ////////////////////////////////////////
    // Data

    typedef logic [`QB_DATA_W-1:0] wordT;   // One register word

endpackage

`default_nettype wire

//--- src/regBusIf.sv
////////////////////////////////////////
// Register request/response interface
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

interface regBusIf;

    import qbridgePkg::*;

    logic       req;                // One cycle request pulse
    logic       write;              // 1 = write, 0 = read
    regSelT     sel;                // Target register
    logic [1:0] byteEn;             // Lane enables, bit 1 = high byte
    wordT       wrData;
    wordT       rdData;             // Valid with done
    reqSrcT     src;                // Set by arbiter on bank side
    logic       done;               // One cycle after req

    // Issuer side
    modport requester
    (
        output req, write, sel, byteEn, wrData, src,
        input  rdData, done
    );

    // Answering side
    modport responder
    (
        input  req, write, sel, byteEn, wrData, src,
        output rdData, done
    );

endinterface

`default_nettype wire

//--- src/hostPort.sv
////////////////////////////////////////
// Host bus port
// Address decode, read data hold, done
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "qbridge_consts.svh"

module hostPort
(
    input  logic                   BRPLYf,
    input  logic                   F_IP_read_enable,
    input  logic                   hostStrobe,          // One cycle access pulse
    input  logic                   hostWrite,
    input  logic [`QB_HOST_AW-1:0] hostAddr,            // Word address
    input  logic [1:0]             hostByteEn,
    input  qbridgePkg::wordT       hostWrData,
    output qbridgePkg::wordT       hostRdData,          // Last read value
    output logic                   hostDone,
    regBusIf.requester             bus
);

    import qbridgePkg::*;

    logic pendingRead;              // Outstanding access is a read

    // Request goes out in the strobe cycle itself
    assign bus.req    = hostStrobe;
    assign bus.write  = hostWrite;
    assign bus.byteEn = hostByteEn;
    assign bus.wrData = hostWrData;

    // Word address to register
    always_comb
    begin
        case (hostAddr)
            `QB_HOST_IP: bus.sel = hostWrite ? regNone : regIp;  // IP is read-only to host
            `QB_HOST_SA: bus.sel = regSa;
            `QB_HOST_CT: bus.sel = regCt;
            default:     bus.sel = regNone;
        endcase
    end

    assign hostDone = bus.done;

    always_ff @(posedge BRPLYf or posedge F_IP_read_enable)
    begin
        if (F_IP_read_enable)
        begin
            pendingRead <= 1'b0;
            hostRdData  <= '0;
        end
        else
        begin
            if (hostStrobe)
                pendingRead <= !hostWrite;
            if (bus.done && pendingRead)
                hostRdData <= bus.rdData;   // Held until next read completes
        end
    end

endmodule

`default_nettype wire

//--- src/qbusSlave.sv
////////////////////////////////////////
// Qbus slave for IP and SA
// Address latch, strobe edges, reply, data drive
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "qbridge_consts.svh"

module qbusSlave
(
    input  logic                 BRPLYf,
    input  logic                 F_IP_read_enable,
    input  logic                 qSync,
    input  logic                 qDin,
    input  logic                 qDout,
    input  logic                 qBs7,                  // I/O page
    input  logic                 qWtbt,                 // High = word write
    input  logic [`QB_DAL_W-1:0] qDalIn,                // Inverted lines
    output logic [`QB_DAL_W-1:0] qDalOut,               // Inverted lines
    output logic                 qDalOe,
    output logic                 qReply,
    regBusIf.requester           bus
);

    import qbridgePkg::*;

    localparam logic [`QB_DAL_W-1:0] ipAddr = `QB_QADDR_IP;
    localparam logic [`QB_DAL_W-1:0] saAddr = `QB_QADDR_SA;

    logic [`QB_DAL_W-1:0] addrTrue;   // Bus address, true polarity
    logic qSyncS;
    logic qDinS, qDinD;             // Two samples for edge detect
    logic qDoutS, qDoutD;
    logic ipSel, saSel, oddByte;    // Latched at address phase
    logic rdRise, wrRise;
    logic readCycle;
    wordT rdHold;

    assign addrTrue = ~qDalIn;
    assign rdRise   = qDinS && !qDinD;
    assign wrRise   = qDoutS && !qDoutD;

    ////////////////////////////////////////
    // Strobe sampling and address phase

    always_ff @(posedge BRPLYf or posedge F_IP_read_enable)
    begin
        if (F_IP_read_enable)
        begin
            qSyncS  <= 1'b0;
            qDinS   <= 1'b0;
            qDinD   <= 1'b0;
            qDoutS  <= 1'b0;
            qDoutD  <= 1'b0;
            ipSel   <= 1'b0;
            saSel   <= 1'b0;
            oddByte <= 1'b0;
        end
        else
        begin
            qSyncS <= qSync;
            qDinS  <= qDin;
            qDinD  <= qDinS;
            qDoutS <= qDout;
            qDoutD <= qDoutS;
            if (qSync && !qSyncS)       // First cycle of SYNC
            begin
                ipSel   <= qBs7 && (addrTrue[12:1] == ipAddr[12:1]);
                saSel   <= qBs7 && (addrTrue[12:1] == saAddr[12:1]);
                oddByte <= addrTrue[0];
            end
        end
    end

    ////////////////////////////////////////
    // Register request

    assign bus.req    = (rdRise || wrRise) && (ipSel || saSel);   // Only when selected
    assign bus.write  = wrRise;
    assign bus.sel    = ipSel ? regIp : (saSel ? regSa : regNone);
    assign bus.wrData = ~qDalIn;
    // Word write uses both lanes, byte write picks by address bit 0
    assign bus.byteEn = (!wrRise || qWtbt) ? 2'b11 : (oddByte ? 2'b10 : 2'b01);

    // Reply held while the strobe persists
    always_ff @(posedge BRPLYf or posedge F_IP_read_enable)
    begin
        if (F_IP_read_enable)
        begin
            qReply    <= 1'b0;
            readCycle <= 1'b0;
        end
        else
        begin
            qReply <= (qReply || bus.done) && (qDin || qDout);
            if (bus.req)
                readCycle <= !bus.write;
        end
    end

    always_ff @(posedge BRPLYf)
    begin
        if (bus.done && readCycle)
            rdHold <= ipSel ? '0 : bus.rdData;  // IP reads as zero
    end

    assign qDalOe  = qReply && readCycle;
    assign qDalOut = qDalOe ? ~rdHold : '0;     // Bus data is inverted

endmodule

`default_nettype wire

//--- src/regArbiter.sv
////////////////////////////////////////
// Fixed-priority arbiter, Qbus first
// One-entry hold slot for the host
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module regArbiter
(
    input  logic        BRPLYf,
    input  logic        F_IP_read_enable,
    regBusIf.responder  hostBus,
    regBusIf.responder  qBus,
    regBusIf.requester  bankBus
);

    import qbridgePkg::*;

    logic       holdValid;          // Host request parked
    logic       holdWrite;
    regSelT     holdSel;
    logic [1:0] holdByteEn;
    wordT       holdWrData;
    reqSrcT     inFlightSrc;        // Owner of the pending done

    ////////////////////////////////////////
    // Forward path

    always_comb
    begin
        bankBus.req = qBus.req || holdValid || hostBus.req;
        if (qBus.req)               // Qbus always wins
        begin
            bankBus.write  = qBus.write;
            bankBus.sel    = qBus.sel;
            bankBus.byteEn = qBus.byteEn;
            bankBus.wrData = qBus.wrData;
            bankBus.src    = srcQbus;
        end
        else if (holdValid)
        begin
            bankBus.write  = holdWrite;
            bankBus.sel    = holdSel;
            bankBus.byteEn = holdByteEn;
            bankBus.wrData = holdWrData;
            bankBus.src    = srcHost;
        end
        else
        begin
            bankBus.write  = hostBus.write;
            bankBus.sel    = hostBus.sel;
            bankBus.byteEn = hostBus.byteEn;
            bankBus.wrData = hostBus.wrData;
            bankBus.src    = srcHost;
        end
    end

    always_ff @(posedge BRPLYf or posedge F_IP_read_enable)
    begin
        if (F_IP_read_enable)
        begin
            holdValid   <= 1'b0;
            inFlightSrc <= srcHost;
        end
        else
        begin
            // Park on collision, release once Qbus is idle
            holdValid <= holdValid ? qBus.req : (qBus.req && hostBus.req);
            if (bankBus.req)
                inFlightSrc <= bankBus.src;
        end
    end

    // Hold slot payload
    always_ff @(posedge BRPLYf)
    begin
        if (qBus.req && hostBus.req && !holdValid)
        begin
            holdWrite  <= hostBus.write;
            holdSel    <= hostBus.sel;
            holdByteEn <= hostBus.byteEn;
            holdWrData <= hostBus.wrData;
        end
    end

    ////////////////////////////////////////
    // Return path, only to the issuer

    assign hostBus.done   = bankBus.done && (inFlightSrc == srcHost);
    assign qBus.done      = bankBus.done && (inFlightSrc == srcQbus);
    assign hostBus.rdData = (inFlightSrc == srcHost) ? bankBus.rdData : '0;
    assign qBus.rdData    = (inFlightSrc == srcQbus) ? bankBus.rdData : '0;

endmodule

`default_nettype wire

//--- src/regBank.sv
////////////////////////////////////////
// IP/SA/CT register bank
// Flags, read-and-clear, interrupt
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "qbridge_consts.svh"

module regBank
(
    input  logic        BRPLYf,
    input  logic        F_IP_read_enable,
    output logic        irq,            // Any flag set
    regBusIf.responder  bus
);

    import qbridgePkg::*;

    wordT saStatus;                 // Written by host, read by Qbus
    wordT saAddress;                // Written by Qbus, read by host
    wordT control;
    logic ipRead, ipWritten, saRead, saWritten;
    wordT flagWord;
    wordT readValue;
    logic fromHost;

    // Byte lane merge
    function automatic wordT mergeBytes(input wordT oldWord, input wordT newWord,
                                        input logic [1:0] be);
        wordT result;
        result = oldWord;
        if (be[0])
            result[7:0] = newWord[7:0];
        if (be[1])
            result[`QB_DATA_W-1:8] = newWord[`QB_DATA_W-1:8];
        return result;
    endfunction

    assign fromHost = (bus.src == srcHost);
    assign irq      = ipRead || ipWritten || saRead || saWritten;

    ////////////////////////////////////////
    // Read mux

    always_comb
    begin
        flagWord = '0;
        flagWord[`QB_FLAG_IPRD] = ipRead;
        flagWord[`QB_FLAG_IPWR] = ipWritten;
        flagWord[`QB_FLAG_SARD] = saRead;
        flagWord[`QB_FLAG_SAWR] = saWritten;
        readValue = '0;             // regNone and Qbus IP read zero
        if (!bus.write)
        begin
            case (bus.sel)
                regIp: if (fromHost) readValue = flagWord;
                regSa: readValue = fromHost ? saAddress : saStatus;
                regCt: if (fromHost) readValue = control;
                default: readValue = '0;
            endcase
        end
    end

    always_ff @(posedge BRPLYf)
    begin
        if (bus.req)
            bus.rdData <= readValue;    // Valid together with done
    end

    ////////////////////////////////////////
    // Register update

    always_ff @(posedge BRPLYf or posedge F_IP_read_enable)
    begin
        if (F_IP_read_enable)
        begin
            saStatus  <= '0;
            saAddress <= '0;
            control   <= '0;
            ipRead    <= 1'b0;
            ipWritten <= 1'b0;
            saRead    <= 1'b0;
            saWritten <= 1'b0;
            bus.done  <= 1'b0;
        end
        else
        begin
            bus.done <= bus.req;
            if (bus.req && fromHost)
            begin
                if (bus.write && bus.sel == regSa)
                    saStatus <= mergeBytes(saStatus, bus.wrData, bus.byteEn);
                else if (bus.write && bus.sel == regCt)
                    control <= mergeBytes(control, bus.wrData, bus.byteEn);
                else if (!bus.write && bus.sel == regIp)
                begin
                    // Read of IP clears all flags
                    ipRead    <= 1'b0;
                    ipWritten <= 1'b0;
                    saRead    <= 1'b0;
                    saWritten <= 1'b0;
                    if (control[`QB_CT_CLEARSA])
                        saAddress <= '0;
                end
            end
            else if (bus.req)           // Qbus side
            begin
                if (bus.write && bus.sel == regIp)
                begin
                    ipWritten <= 1'b1;  // Controller init
                    saStatus  <= '0;
                    control   <= '0;
                end
                else if (bus.write && bus.sel == regSa)
                begin
                    saAddress <= mergeBytes(saAddress, bus.wrData, bus.byteEn);
                    saWritten <= 1'b1;
                end
                else if (!bus.write && bus.sel == regIp)
                    ipRead <= 1'b1;     // Poll
                else if (!bus.write && bus.sel == regSa)
                    saRead <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/qbridgeTop.sv
////////////////////////////////////////
// Register bridge top level
// Host port, Qbus slave, arbiter, bank
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "qbridge_consts.svh"

module qbridgeTop
(
    input  logic                   BRPLYf,              // Clock
    input  logic                   F_IP_read_enable,    // Async reset
    // Host bus
    input  logic                   hostStrobe,
    input  logic                   hostWrite,
    input  logic [`QB_HOST_AW-1:0] hostAddr,
    input  logic [1:0]             hostByteEn,
    input  logic [`QB_DATA_W-1:0]  hostWrData,
    output logic [`QB_DATA_W-1:0]  hostRdData,
    output logic                   hostDone,
    // Qbus slave
    input  logic                   qSync,
    input  logic                   qDin,
    input  logic                   qDout,
    input  logic                   qBs7,
    input  logic                   qWtbt,
    input  logic [`QB_DAL_W-1:0]   qDalIn,              // Inverted
    output logic [`QB_DAL_W-1:0]   qDalOut,             // Inverted
    output logic                   qDalOe,
    output logic                   qReply,
    output logic                   irq                  // To host
);

    regBusIf hostBus ();            // Host port to arbiter
    regBusIf qBus ();               // Qbus slave to arbiter
    regBusIf bankBus ();            // Arbiter to bank

    hostPort i_hostPort
    (
        .BRPLYf           (BRPLYf),
        .F_IP_read_enable (F_IP_read_enable),
        .hostStrobe       (hostStrobe),
        .hostWrite        (hostWrite),
        .hostAddr         (hostAddr),
        .hostByteEn       (hostByteEn),
        .hostWrData       (hostWrData),
        .hostRdData       (hostRdData),
        .hostDone         (hostDone),
        .bus              (hostBus.requester)
    );

    qbusSlave i_qbusSlave
    (
        .BRPLYf           (BRPLYf),
        .F_IP_read_enable (F_IP_read_enable),
        .qSync            (qSync),
        .qDin             (qDin),
        .qDout            (qDout),
        .qBs7             (qBs7),
        .qWtbt            (qWtbt),
        .qDalIn           (qDalIn),
        .qDalOut          (qDalOut),
        .qDalOe           (qDalOe),
        .qReply           (qReply),
        .bus              (qBus.requester)
    );

    regArbiter i_regArbiter
    (
        .BRPLYf           (BRPLYf),
        .F_IP_read_enable (F_IP_read_enable),
        .hostBus          (hostBus.responder),
        .qBus             (qBus.responder),
        .bankBus          (bankBus.requester)
    );

    regBank i_regBank
    (
        .BRPLYf           (BRPLYf),
        .F_IP_read_enable (F_IP_read_enable),
        .irq              (irq),
        .bus              (bankBus.responder)
    );

endmodule

`default_nettype wire

//--- dv/qbridgeTb.sv
////////////////////////////////////////
// Register bridge testbench
// Host and Qbus tasks, checks, report
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "qbridge_consts.svh"

module qbridgeTb;

    import qbridgePkg::*;

    localparam int hostLimit  = 10;             // Cycles to wait for hostDone
    localparam int replyLimit = 20;             // Cycles to wait for qReply
    localparam int quietWin   = 12;             // Window for unselected reads
    localparam logic [`QB_DAL_W-1:0] unmapped = 16'o172160;   // Nothing here

    logic BRPLYf, F_IP_read_enable;
    logic hostStrobe, hostWrite, hostDone;
    logic [`QB_HOST_AW-1:0] hostAddr;
    logic [1:0] hostByteEn;
    logic [`QB_DATA_W-1:0] hostWrData, hostRdData;
    logic qSync, qDin, qDout, qBs7, qWtbt, qDalOe, qReply, irq;
    logic [`QB_DAL_W-1:0] qDalIn, qDalOut;      // Inverted bus lines

    int errorCount, testCount, testStartErrors, seedDummy, hostCycles;
    logic [`QB_DATA_W-1:0] a, b, c, d, rd;

    qbridgeTop i_qbridgeTop
    (
        .BRPLYf           (BRPLYf),
        .F_IP_read_enable (F_IP_read_enable),
        .hostStrobe       (hostStrobe),
        .hostWrite        (hostWrite),
        .hostAddr         (hostAddr),
        .hostByteEn       (hostByteEn),
        .hostWrData       (hostWrData),
        .hostRdData       (hostRdData),
        .hostDone         (hostDone),
        .qSync            (qSync),
        .qDin             (qDin),
        .qDout            (qDout),
        .qBs7             (qBs7),
        .qWtbt            (qWtbt),
        .qDalIn           (qDalIn),
        .qDalOut          (qDalOut),
        .qDalOe           (qDalOe),
        .qReply           (qReply),
        .irq              (irq)
    );

    always #4 BRPLYf = ~BRPLYf;                 // 8 ns period

    ////////////////////////////////////////
    // Checks

    task automatic checkWord(input string what, input logic [`QB_DATA_W-1:0] got,
                             input logic [`QB_DATA_W-1:0] expected);
        assert (got === expected)
        else
        begin
            $display("Fail at %0t: %s is %h, expected %h", $time, what, got, expected);
            errorCount++;
        end
    endtask

    task automatic checkLevel(input string what, input logic got, input logic expected);
        assert (got === expected)
        else
        begin
            $display("Fail at %0t: %s is %b, expected %b", $time, what, got, expected);
            errorCount++;
        end
    endtask

    // Bus rules that hold in every cycle
    always @(negedge BRPLYf)
    begin
        if (!F_IP_read_enable)
        begin
            assert (!qDalOe || qReply)
            else
            begin
                $display("Fail at %0t: qDalOe high without qReply", $time);
                errorCount++;
            end
            assert (qDalOe || qDalOut == '0)
            else
            begin
                $display("Fail at %0t: qDalOut driven while qDalOe low", $time);
                errorCount++;
            end
        end
    end

    ////////////////////////////////////////
    // Stimulus data

    // One random data word
    function automatic logic [`QB_DATA_W-1:0] randomWord();
        logic [31:0] r;
        r = $urandom;
        return r[`QB_DATA_W-1:0];
    endfunction

    ////////////////////////////////////////
    // Host bus

    task automatic hostAccess(input logic write, input logic [`QB_HOST_AW-1:0] addr,
                              input logic [1:0] be, input logic [`QB_DATA_W-1:0] data,
                              output logic [`QB_DATA_W-1:0] rdData, output int cycles);
        @(negedge BRPLYf);
        hostStrobe = 1'b1;                      // Single pulse
        hostWrite  = write;
        hostAddr   = addr;
        hostByteEn = be;
        hostWrData = data;
        @(negedge BRPLYf);
        hostStrobe = 1'b0;
        cycles = 1;
        while (!hostDone && cycles < hostLimit)
        begin
            @(negedge BRPLYf);
            cycles++;
        end
        if (!hostDone)
        begin
            $display("Host access timed out, no hostDone after %0d cycles", cycles);
            errorCount++;
        end
        @(negedge BRPLYf);                      // Read data lands after done
        rdData = hostRdData;
    endtask

    ////////////////////////////////////////
    // Qbus

    task automatic waitReply(input logic level);
        int cycles;
        cycles = 0;
        while (qReply !== level && cycles < replyLimit)
        begin
            @(negedge BRPLYf);
            cycles++;
        end
        if (qReply !== level)
        begin
            $display("Qbus cycle timed out, qReply never went %b", level);
            errorCount++;
        end
        else if (level)
        begin
            assert (cycles >= 2 && cycles <= 3)
            else
            begin
                $display("Fail at %0t: qReply latency %0d cycles", $time, cycles);
                errorCount++;
            end
        end
        else
        begin
            // Reply drops in the cycle after the strobe
            assert (cycles <= 1)
            else
            begin
                $display("Fail at %0t: qReply fell %0d cycles after strobe", $time, cycles);
                errorCount++;
            end
        end
    endtask

    task automatic qbusAddress(input logic [`QB_DAL_W-1:0] addr, input logic bs7);
        @(negedge BRPLYf);
        qDalIn = ~addr;                         // Lines are active low
        qBs7   = bs7;
        qSync  = 1'b1;
    endtask

    task automatic qbusEnd;
        qSync  = 1'b0;
        qBs7   = 1'b0;
        qWtbt  = 1'b0;
        qDalIn = '1;                            // Released
    endtask

    task automatic qbusRead(input logic [`QB_DAL_W-1:0] addr,
                            output logic [`QB_DATA_W-1:0] data);
        qbusAddress(addr, 1'b1);
        @(negedge BRPLYf);
        qDalIn = '1;
        qDin   = 1'b1;
        waitReply(1'b1);
        checkLevel("qDalOe during read", qDalOe, 1'b1);
        data = ~qDalOut;
        @(negedge BRPLYf);
        qDin = 1'b0;
        waitReply(1'b0);
        qbusEnd();
    endtask

    task automatic qbusWrite(input logic [`QB_DAL_W-1:0] addr,
                             input logic [`QB_DATA_W-1:0] data, input logic word);
        qbusAddress(addr, 1'b1);
        @(negedge BRPLYf);
        qDalIn = ~data;
        qWtbt  = word;                          // Low means byte write
        qDout  = 1'b1;
        waitReply(1'b1);
        @(negedge BRPLYf);
        qDout = 1'b0;
        waitReply(1'b0);
        qbusEnd();
    endtask

    // Read that must stay unanswered
    task automatic qbusNoReply(input logic [`QB_DAL_W-1:0] addr, input logic bs7);
        qbusAddress(addr, bs7);
        @(negedge BRPLYf);
        qDalIn = '1;
        qDin   = 1'b1;
        repeat (quietWin)
        begin
            @(negedge BRPLYf);
            checkLevel("qReply on unselected read", qReply, 1'b0);
        end
        qDin = 1'b0;
        @(negedge BRPLYf);
        qbusEnd();
    endtask

    ////////////////////////////////////////
    // Report

    task automatic reportTest(input string name);
        testCount++;
        if (errorCount == testStartErrors)
            $display("Test %-12s ok", name);
        else
            $display("Test %-12s %0d errors", name, errorCount - testStartErrors);
        testStartErrors = errorCount;
    endtask

    initial
    begin
        seedDummy = $urandom(36);
        errorCount = 0;
        testCount = 0;
        testStartErrors = 0;
        BRPLYf = 1'b0;
        F_IP_read_enable = 1'b1;
        hostStrobe = 1'b0;
        hostWrite  = 1'b0;
        hostAddr   = '0;
        hostByteEn = '0;
        hostWrData = '0;
        qSync = 1'b0;
        qDin  = 1'b0;
        qDout = 1'b0;
        qBs7  = 1'b0;
        qWtbt = 1'b0;
        qDalIn = '1;
        repeat (3) @(posedge BRPLYf);
        @(negedge BRPLYf);
        F_IP_read_enable = 1'b0;

        // Quiet outputs, zero registers
        checkLevel("qReply", qReply, 1'b0);
        checkLevel("qDalOe", qDalOe, 1'b0);
        checkLevel("irq", irq, 1'b0);
        checkLevel("hostDone", hostDone, 1'b0);
        hostAccess(1'b0, `QB_HOST_SA, 2'b11, '0, rd, hostCycles);
        checkWord("host SA after reset", rd, '0);
        hostAccess(1'b0, `QB_HOST_CT, 2'b11, '0, rd, hostCycles);
        checkWord("host CT after reset", rd, '0);
        reportTest("reset");

        // Host fills SA status, Qbus reads it
        a = randomWord();
        b = randomWord();
        hostAccess(1'b1, `QB_HOST_SA, 2'b11, a, rd, hostCycles);
        hostAccess(1'b1, `QB_HOST_SA, 2'b01, b, rd, hostCycles);
        qbusRead(`QB_QADDR_SA, rd);
        checkWord("Qbus SA read", rd, {a[15:8], b[7:0]});
        checkLevel("irq after SA read", irq, 1'b1);
        reportTest("hostToQbus");

        // Word write then odd byte write
        c = randomWord();
        d = randomWord();
        qbusWrite(`QB_QADDR_SA, c, 1'b1);
        qbusWrite(`QB_QADDR_SA + 16'd1, d, 1'b0);
        hostAccess(1'b0, `QB_HOST_SA, 2'b11, '0, rd, hostCycles);
        checkWord("host SA read", rd, {d[15:8], c[7:0]});
        reportTest("qbusToHost");

        // Flags read and clear
        hostAccess(1'b0, `QB_HOST_IP, 2'b11, '0, rd, hostCycles);
        checkLevel("irq after clear", irq, 1'b0);
        qbusRead(`QB_QADDR_SA, rd);
        qbusWrite(`QB_QADDR_SA, randomWord(), 1'b1);
        hostAccess(1'b0, `QB_HOST_IP, 2'b11, '0, rd, hostCycles);
        checkWord("IP flags", rd, (16'd1 << `QB_FLAG_SARD) | (16'd1 << `QB_FLAG_SAWR));
        hostAccess(1'b0, `QB_HOST_IP, 2'b11, '0, rd, hostCycles);
        checkWord("IP flags again", rd, '0);
        checkLevel("irq after IP read", irq, 1'b0);
        hostAccess(1'b1, `QB_HOST_CT, 2'b11, 16'd1 << `QB_CT_CLEARSA, rd, hostCycles);
        a = randomWord() | 16'h0001;            // Never zero
        qbusWrite(`QB_QADDR_SA, a, 1'b1);
        hostAccess(1'b0, `QB_HOST_SA, 2'b11, '0, rd, hostCycles);
        checkWord("SA address before clear", rd, a);
        hostAccess(1'b0, `QB_HOST_IP, 2'b11, '0, rd, hostCycles);
        hostAccess(1'b0, `QB_HOST_SA, 2'b11, '0, rd, hostCycles);
        checkWord("SA address after clear", rd, '0);
        reportTest("readClear");

        // Qbus IP write is a controller init
        hostAccess(1'b1, `QB_HOST_SA, 2'b11, randomWord() | 16'h0001, rd, hostCycles);
        hostAccess(1'b1, `QB_HOST_CT, 2'b11, randomWord() | 16'h0001, rd, hostCycles);
        hostAccess(1'b0, `QB_HOST_IP, 2'b11, '0, rd, hostCycles);
        qbusWrite(`QB_QADDR_IP, randomWord(), 1'b1);
        checkLevel("irq after IP write", irq, 1'b1);
        hostAccess(1'b0, `QB_HOST_IP, 2'b11, '0, rd, hostCycles);
        checkWord("IP flags", rd, 16'd1 << `QB_FLAG_IPWR);
        hostAccess(1'b0, `QB_HOST_CT, 2'b11, '0, rd, hostCycles);
        checkWord("CT after init", rd, '0);
        qbusRead(`QB_QADDR_SA, rd);
        checkWord("SA status after init", rd, '0);
        reportTest("qbusIpWrite");

        // Unselected reads, then host read colliding with Qbus write
        qbusNoReply(`QB_QADDR_SA, 1'b0);
        qbusNoReply(unmapped, 1'b1);
        b = randomWord();
        fork
            qbusWrite(`QB_QADDR_SA, b, 1'b1);
            begin
                repeat (2) @(negedge BRPLYf);   // Lands in the Qbus request cycle
                hostAccess(1'b0, `QB_HOST_SA, 2'b11, '0, rd, hostCycles);
            end
        join
        assert (hostCycles <= 2)
        else
        begin
            $display("Fail at %0t: hostDone after %0d cycles", $time, hostCycles);
            errorCount++;
        end
        checkWord("host SA after collision", rd, b);
        reportTest("contention");

        $display("%0d tests, %0d errors", testCount, errorCount);
        if (errorCount == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+src
src/qbridgePkg.sv
src/regBusIf.sv
src/hostPort.sv
src/qbusSlave.sv
src/regArbiter.sv
src/regBank.sv
src/qbridgeTop.sv
dv/qbridgeTb.sv
